// File: rename_pkg.sv
package rename_pkg;

    //////////////////////////////////////////////////
    // Architectural constants
    //////////////////////////////////////////////////

    // Register count fixed by the ISA
    localparam int ARCH_REGS = 32;

    // Width of an architectural register index
    localparam int ARCH_IDX_W = $clog2(ARCH_REGS);

    //////////////////////////////////////////////////
    // Shared types
    //////////////////////////////////////////////////

    // Architectural register index
    typedef logic [ARCH_IDX_W-1:0] arch_reg_t;

    // Reorder buffer entry state
    // EMPTY -> WAIT at dispatch, WAIT -> DONE at completion,
    // DONE -> EMPTY at retirement or flush
    typedef enum logic [1:0] {
        ROB_EMPTY = 2'd0,
        ROB_WAIT  = 2'd1,
        ROB_DONE  = 2'd2
    } rob_state_e;

endpackage

// File: map_table.sv
`timescale 1ns/100ps

module map_table #(
    parameter int PHYS_REGS = 64
) (
    input  logic                                                      clock,
    input  logic                                                      rst,
    input  logic                                                      alloc,
    input  logic                                                      flush,
    input  rename_pkg::arch_reg_t                                     dispatch_rd,
    input  rename_pkg::arch_reg_t                                     dispatch_rs1,
    input  rename_pkg::arch_reg_t                                     dispatch_rs2,
    input  logic [$clog2(PHYS_REGS)-1:0]                              free_tag,
    input  logic [rename_pkg::ARCH_REGS-1:0][$clog2(PHYS_REGS)-1:0]   arch_image,
    output logic [$clog2(PHYS_REGS)-1:0]                              old_tag,
    output logic [$clog2(PHYS_REGS)-1:0]                              src1_tag,
    output logic [$clog2(PHYS_REGS)-1:0]                              src2_tag
);

    localparam int TAG_W = $clog2(PHYS_REGS);

    // Speculative map, one physical tag per architectural register
    logic [rename_pkg::ARCH_REGS-1:0][TAG_W-1:0] spec_map;

    //////////////////////////////////////////////////
    // Lookups
    //////////////////////////////////////////////////

    // Previous mapping of rd, stored by the ROB for release at retire
    assign old_tag = spec_map[dispatch_rd];

    // Source lookups use the map before this instruction's own write,
    // so rs == rd still sees the older producer
    always_ff @(posedge clock) begin
        if (alloc) begin
            src1_tag <= spec_map[dispatch_rs1];
            src2_tag <= spec_map[dispatch_rs2];
        end
    end

    //////////////////////////////////////////////////
    // Map update
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            // Identity map, arch reg i lives in phys reg i
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                spec_map[i] <= TAG_W'(i);
            end
        end else if (flush) begin
            // Roll back to the committed state
            spec_map <= arch_image;
        end else if (alloc) begin
            // New producer of rd
            spec_map[dispatch_rd] <= free_tag;
        end
    end

endmodule

// File: free_list.sv
`timescale 1ns/100ps

module free_list #(
    parameter int PHYS_REGS = 64
) (
    input  logic                         clock,
    input  logic                         rst,
    input  logic                         alloc,
    input  logic                         flush,
    input  logic                         commit_valid,
    input  logic [$clog2(PHYS_REGS)-1:0] commit_freed_tag,
    input  logic [PHYS_REGS-1:0]         mapped_mask,
    output logic [$clog2(PHYS_REGS)-1:0] free_tag,
    output logic                         free_avail
);

    localparam int TAG_W = $clog2(PHYS_REGS);

    // One bit per physical register, set while the register is free
    logic [PHYS_REGS-1:0] free_bits;
    logic [PHYS_REGS-1:0] free_bits_next;

    //////////////////////////////////////////////////
    // Lowest-first pick
    //////////////////////////////////////////////////

    // Priority encoder, scan from the top so the lowest set bit wins
    always_comb begin
        free_tag = '0;
        for (int i = PHYS_REGS - 1; i >= 0; i--) begin
            if (free_bits[i]) begin
                free_tag = TAG_W'(i);
            end
        end
    end

    // Any register left to hand out
    assign free_avail = |free_bits;

    //////////////////////////////////////////////////
    // Bitmap update
    //////////////////////////////////////////////////

    always_comb begin
        free_bits_next = free_bits;
        // Chosen register leaves the pool
        if (alloc) begin
            free_bits_next[free_tag] = 1'b0;
        end
        // Old tag of the retiring instruction rejoins the pool
        // never the same register as the pick, it is still mapped
        if (commit_valid) begin
            free_bits_next[commit_freed_tag] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            // Low registers hold the identity map, the rest are free
            for (int i = 0; i < PHYS_REGS; i++) begin
                free_bits[i] <= (i >= rename_pkg::ARCH_REGS);
            end
        end else if (flush) begin
            // Everything not in the committed map is free again
            free_bits <= ~mapped_mask;
        end else begin
            free_bits <= free_bits_next;
        end
    end

endmodule

// File: reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer #(
    parameter int PHYS_REGS = 64,
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clock,
    input  logic                         rst,
    input  logic                         dispatch_valid,
    input  rename_pkg::arch_reg_t        dispatch_rd,
    input  logic [$clog2(PHYS_REGS)-1:0] free_tag,
    input  logic                         free_avail,
    input  logic [$clog2(PHYS_REGS)-1:0] old_tag,
    input  logic                         complete_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] complete_idx,
    input  logic                         flush,
    output logic                         dispatch_ready,
    output logic                         alloc,
    output logic                         rename_valid,
    output logic [$clog2(ROB_DEPTH)-1:0] rename_idx,
    output logic [$clog2(PHYS_REGS)-1:0] rename_dest_tag,
    output logic [$clog2(PHYS_REGS)-1:0] rename_old_tag,
    output logic                         commit_valid,
    output rename_pkg::arch_reg_t        commit_rd,
    output logic [$clog2(PHYS_REGS)-1:0] commit_tag,
    output logic [$clog2(PHYS_REGS)-1:0] commit_freed_tag
);

    localparam int TAG_W = $clog2(PHYS_REGS);
    localparam int IDX_W = $clog2(ROB_DEPTH);

    // Entry state, the only per-entry control field
    rename_pkg::rob_state_e state_q [ROB_DEPTH];

    // Entry payload
    rename_pkg::arch_reg_t  rd_q      [ROB_DEPTH];
    logic [TAG_W-1:0]       new_tag_q [ROB_DEPTH];
    logic [TAG_W-1:0]       old_tag_q [ROB_DEPTH];

    // Queue pointers, head is the oldest entry
    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [IDX_W:0]   count;

    logic full;
    logic complete_hit;

    //////////////////////////////////////////////////
    // Dispatch acceptance
    //////////////////////////////////////////////////

    assign full           = (count == (IDX_W + 1)'(ROB_DEPTH));
    assign dispatch_ready = !full && free_avail;

    // Single point where a dispatch is accepted
    // map table and free list write on this
    assign alloc = dispatch_valid && dispatch_ready && !flush;

    // Completions only count against a waiting entry
    assign complete_hit = complete_valid && (state_q[complete_idx] == rename_pkg::ROB_WAIT);

    //////////////////////////////////////////////////
    // Retirement of the head
    //////////////////////////////////////////////////

    assign commit_valid     = !flush && (state_q[head] == rename_pkg::ROB_DONE);
    assign commit_rd        = rd_q[head];
    assign commit_tag       = new_tag_q[head];
    assign commit_freed_tag = old_tag_q[head];

    //////////////////////////////////////////////////
    // Control state
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            // Empty queue, both pointers back to slot 0
            for (int i = 0; i < ROB_DEPTH; i++) begin
                state_q[i] <= rename_pkg::ROB_EMPTY;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // Tail slot is empty whenever alloc is high
            if (alloc) begin
                state_q[tail] <= rename_pkg::ROB_WAIT;
                tail          <= tail + 1'b1;
            end
            // WAIT entry cannot be the DONE head, no clash with retire
            if (complete_hit) begin
                state_q[complete_idx] <= rename_pkg::ROB_DONE;
            end
            if (commit_valid) begin
                state_q[head] <= rename_pkg::ROB_EMPTY;
                head          <= head + 1'b1;
            end
            case ({alloc, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Entry payload and rename response
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (alloc) begin
            rd_q[tail]      <= dispatch_rd;
            new_tag_q[tail] <= free_tag;
            old_tag_q[tail] <= old_tag;
        end
    end

    // Response one cycle after the accepted dispatch
    always_ff @(posedge clock) begin
        if (rst) begin
            rename_valid <= 1'b0;
        end else begin
            rename_valid <= alloc;
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            rename_idx      <= tail;
            rename_dest_tag <= free_tag;
            rename_old_tag  <= old_tag;
        end
    end

endmodule

// File: arch_map_table.sv
`timescale 1ns/100ps

module arch_map_table #(
    parameter int PHYS_REGS = 64
) (
    input  logic                                                      clock,
    input  logic                                                      rst,
    input  logic                                                      commit_valid,
    input  rename_pkg::arch_reg_t                                     commit_rd,
    input  logic [$clog2(PHYS_REGS)-1:0]                              commit_tag,
    output logic [rename_pkg::ARCH_REGS-1:0][$clog2(PHYS_REGS)-1:0]   arch_image,
    output logic [PHYS_REGS-1:0]                                      mapped_mask
);

    localparam int TAG_W = $clog2(PHYS_REGS);

    // Committed map, changes only at retirement
    logic [rename_pkg::ARCH_REGS-1:0][TAG_W-1:0] arch_map;

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                arch_map[i] <= TAG_W'(i);
            end
        end else if (commit_valid) begin
            // Retiring instruction becomes the committed producer of rd
            arch_map[commit_rd] <= commit_tag;
        end
    end

    //////////////////////////////////////////////////
    // Recovery outputs
    //////////////////////////////////////////////////

    // Restore image for the speculative map
    assign arch_image = arch_map;

    // Physical registers held by the committed state
    // complement of this is the free set after a flush
    always_comb begin
        mapped_mask = '0;
        for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
            mapped_mask[arch_map[i]] = 1'b1;
        end
    end

endmodule

// File: rename_core.sv
`timescale 1ns/100ps

module rename_core #(
    parameter int PHYS_REGS = 64,
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clock,
    input  logic                         rst,

    // Dispatch
    input  logic                         dispatch_valid,
    input  rename_pkg::arch_reg_t        dispatch_rd,
    input  rename_pkg::arch_reg_t        dispatch_rs1,
    input  rename_pkg::arch_reg_t        dispatch_rs2,
    output logic                         dispatch_ready,

    // Completion and recovery
    input  logic                         complete_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] complete_idx,
    input  logic                         flush,

    // Rename response
    output logic                         rename_valid,
    output logic [$clog2(PHYS_REGS)-1:0] rename_src1_tag,
    output logic [$clog2(PHYS_REGS)-1:0] rename_src2_tag,
    output logic [$clog2(PHYS_REGS)-1:0] rename_dest_tag,
    output logic [$clog2(PHYS_REGS)-1:0] rename_old_tag,
    output logic [$clog2(ROB_DEPTH)-1:0] rename_idx,

    // Retirement
    output logic                         commit_valid,
    output rename_pkg::arch_reg_t        commit_rd,
    output logic [$clog2(PHYS_REGS)-1:0] commit_tag,
    output logic [$clog2(PHYS_REGS)-1:0] commit_freed_tag
);

    // Accepted dispatch, write enable for map and free list
    logic                                                    alloc;
    // Lowest free register and pool status
    logic [$clog2(PHYS_REGS)-1:0]                            free_tag;
    logic                                                    free_avail;
    // Current mapping of rd before the write
    logic [$clog2(PHYS_REGS)-1:0]                            old_tag;
    // Committed state for flush recovery
    logic [rename_pkg::ARCH_REGS-1:0][$clog2(PHYS_REGS)-1:0] arch_image;
    logic [PHYS_REGS-1:0]                                    mapped_mask;

    //////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////

    map_table #(
        .PHYS_REGS (PHYS_REGS)
    ) u_map_table (
        .clock        (clock),
        .rst          (rst),
        .alloc        (alloc),
        .flush        (flush),
        .dispatch_rd  (dispatch_rd),
        .dispatch_rs1 (dispatch_rs1),
        .dispatch_rs2 (dispatch_rs2),
        .free_tag     (free_tag),
        .arch_image   (arch_image),
        .old_tag      (old_tag),
        .src1_tag     (rename_src1_tag),
        .src2_tag     (rename_src2_tag)
    );

    free_list #(
        .PHYS_REGS (PHYS_REGS)
    ) u_free_list (
        .clock            (clock),
        .rst              (rst),
        .alloc            (alloc),
        .flush            (flush),
        .commit_valid     (commit_valid),
        .commit_freed_tag (commit_freed_tag),
        .mapped_mask      (mapped_mask),
        .free_tag         (free_tag),
        .free_avail       (free_avail)
    );

    //////////////////////////////////////////////////
    // In-order queue and retirement
    //////////////////////////////////////////////////

    reorder_buffer #(
        .PHYS_REGS (PHYS_REGS),
        .ROB_DEPTH (ROB_DEPTH)
    ) u_reorder_buffer (
        .clock            (clock),
        .rst              (rst),
        .dispatch_valid   (dispatch_valid),
        .dispatch_rd      (dispatch_rd),
        .free_tag         (free_tag),
        .free_avail       (free_avail),
        .old_tag          (old_tag),
        .complete_valid   (complete_valid),
        .complete_idx     (complete_idx),
        .flush            (flush),
        .dispatch_ready   (dispatch_ready),
        .alloc            (alloc),
        .rename_valid     (rename_valid),
        .rename_idx       (rename_idx),
        .rename_dest_tag  (rename_dest_tag),
        .rename_old_tag   (rename_old_tag),
        .commit_valid     (commit_valid),
        .commit_rd        (commit_rd),
        .commit_tag       (commit_tag),
        .commit_freed_tag (commit_freed_tag)
    );

    //////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////

    arch_map_table #(
        .PHYS_REGS (PHYS_REGS)
    ) u_arch_map_table (
        .clock        (clock),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_tag   (commit_tag),
        .arch_image   (arch_image),
        .mapped_mask  (mapped_mask)
    );

endmodule

// File: tb_rename_core.sv
`timescale 1ns/100ps

module tb_rename_core;

    localparam int PHYS_REGS   = 64;
    localparam int ROB_DEPTH   = 16;
    localparam int HALF_PERIOD = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int TIMEOUT     = 50;

    logic                         clock;
    logic                         rst;
    logic                         dispatch_valid;
    rename_pkg::arch_reg_t        dispatch_rd;
    rename_pkg::arch_reg_t        dispatch_rs1;
    rename_pkg::arch_reg_t        dispatch_rs2;
    logic                         dispatch_ready;
    logic                         complete_valid;
    logic [$clog2(ROB_DEPTH)-1:0] complete_idx;
    logic                         flush;
    logic                         rename_valid;
    logic [$clog2(PHYS_REGS)-1:0] rename_src1_tag;
    logic [$clog2(PHYS_REGS)-1:0] rename_src2_tag;
    logic [$clog2(PHYS_REGS)-1:0] rename_dest_tag;
    logic [$clog2(PHYS_REGS)-1:0] rename_old_tag;
    logic [$clog2(ROB_DEPTH)-1:0] rename_idx;
    logic                         commit_valid;
    rename_pkg::arch_reg_t        commit_rd;
    logic [$clog2(PHYS_REGS)-1:0] commit_tag;
    logic [$clog2(PHYS_REGS)-1:0] commit_freed_tag;

    int seed;
    int check_count;
    int error_count;

    // Reference model of maps, free pool and in-flight queue
    int spec_map [rename_pkg::ARCH_REGS];
    int arch_map [rename_pkg::ARCH_REGS];
    bit free_bits [PHYS_REGS];
    int q_rd [$];
    int q_new [$];
    int q_old [$];
    int q_idx [$];
    int model_tail;

    rename_core #(
        .PHYS_REGS (PHYS_REGS),
        .ROB_DEPTH (ROB_DEPTH)
    ) DUT (
        .clock            (clock),
        .rst              (rst),
        .dispatch_valid   (dispatch_valid),
        .dispatch_rd      (dispatch_rd),
        .dispatch_rs1     (dispatch_rs1),
        .dispatch_rs2     (dispatch_rs2),
        .dispatch_ready   (dispatch_ready),
        .complete_valid   (complete_valid),
        .complete_idx     (complete_idx),
        .flush            (flush),
        .rename_valid     (rename_valid),
        .rename_src1_tag  (rename_src1_tag),
        .rename_src2_tag  (rename_src2_tag),
        .rename_dest_tag  (rename_dest_tag),
        .rename_old_tag   (rename_old_tag),
        .rename_idx       (rename_idx),
        .commit_valid     (commit_valid),
        .commit_rd        (commit_rd),
        .commit_tag       (commit_tag),
        .commit_freed_tag (commit_freed_tag)
    );

    always #HALF_PERIOD clock = ~clock;

    //////////////////////////////////////////////////
    // Model helpers
    //////////////////////////////////////////////////

    // Identity maps with upper registers free and nothing in flight
    function automatic void model_reset();
        for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
            spec_map[i] = i;
            arch_map[i] = i;
        end
        for (int i = 0; i < PHYS_REGS; i++) begin
            free_bits[i] = (i >= rename_pkg::ARCH_REGS);
        end
        q_rd.delete();
        q_new.delete();
        q_old.delete();
        q_idx.delete();
        model_tail = 0;
    endfunction

    // Roll back to the committed map and free whatever it does not hold
    function automatic void model_flush();
        for (int i = 0; i < PHYS_REGS; i++) begin
            free_bits[i] = 1'b1;
        end
        for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
            spec_map[i] = arch_map[i];
            free_bits[arch_map[i]] = 1'b0;
        end
        q_rd.delete();
        q_new.delete();
        q_old.delete();
        q_idx.delete();
        model_tail = 0;
    endfunction

    function automatic int lowest_free();
        for (int i = 0; i < PHYS_REGS; i++) begin
            if (free_bits[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic rename_pkg::arch_reg_t rand_reg();
        int r;
        r = $random(seed);
        return rename_pkg::arch_reg_t'(r[rename_pkg::ARCH_IDX_W-1:0]);
    endfunction

    //////////////////////////////////////////////////
    // Drive and check tasks
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
            error_count++;
        end
    endtask

    // Inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic wait_rename(output int cycles);
        cycles = 0;
        while (rename_valid !== 1'b1 && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (rename_valid !== 1'b1) begin
            $display("Timeout at %0t ns: no rename response after %0d cycles", $time, TIMEOUT);
            error_count++;
        end
    endtask

    task automatic wait_commit(output int cycles);
        cycles = 0;
        while (commit_valid !== 1'b1 && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (commit_valid !== 1'b1) begin
            $display("Timeout at %0t ns: no commit after %0d cycles", $time, TIMEOUT);
            error_count++;
        end
    endtask

    // One accepted dispatch with its response checked against the model
    task automatic dispatch_one(input rename_pkg::arch_reg_t rd, input rename_pkg::arch_reg_t rs1,
                                input rename_pkg::arch_reg_t rs2);
        int exp_src1;
        int exp_src2;
        int exp_dest;
        int exp_old;
        int exp_idx;
        int cycles;
        check_value("dispatch_ready", dispatch_ready, 1);
        // Sources see the map before this instruction's write
        exp_src1 = spec_map[rs1];
        exp_src2 = spec_map[rs2];
        exp_dest = lowest_free();
        exp_old  = spec_map[rd];
        exp_idx  = model_tail;
        dispatch_valid = 1'b1;
        dispatch_rd    = rd;
        dispatch_rs1   = rs1;
        dispatch_rs2   = rs2;
        next_cycle();
        dispatch_valid = 1'b0;
        wait_rename(cycles);
        check_value("rename_latency", cycles, 0);
        check_value("rename_src1_tag", rename_src1_tag, exp_src1);
        check_value("rename_src2_tag", rename_src2_tag, exp_src2);
        check_value("rename_dest_tag", rename_dest_tag, exp_dest);
        check_value("rename_old_tag", rename_old_tag, exp_old);
        check_value("rename_idx", rename_idx, exp_idx);
        spec_map[rd] = exp_dest;
        free_bits[exp_dest] = 1'b0;
        q_rd.push_back(rd);
        q_new.push_back(exp_dest);
        q_old.push_back(exp_old);
        q_idx.push_back(exp_idx);
        model_tail = (model_tail + 1) % ROB_DEPTH;
    endtask

    task automatic complete_entry(input int idx);
        complete_valid = 1'b1;
        complete_idx   = idx[$clog2(ROB_DEPTH)-1:0];
        next_cycle();
        complete_valid = 1'b0;
    endtask

    // Head commit is expected in the cycle after its completion
    task automatic retire_head();
        int cycles;
        wait_commit(cycles);
        check_value("commit_latency", cycles, 0);
        check_value("commit_rd", commit_rd, q_rd[0]);
        check_value("commit_tag", commit_tag, q_new[0]);
        check_value("commit_freed_tag", commit_freed_tag, q_old[0]);
        arch_map[q_rd[0]] = q_new[0];
        free_bits[q_old[0]] = 1'b1;
        void'(q_rd.pop_front());
        void'(q_new.pop_front());
        void'(q_old.pop_front());
        void'(q_idx.pop_front());
        next_cycle();
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("Test %s finished with %0d errors", name, error_count - errors_before);
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic reset_rename();
        int errors_before;
        rename_pkg::arch_reg_t rd;
        errors_before = error_count;
        rd = rand_reg();
        check_value("rename_valid", rename_valid, 0);
        check_value("commit_valid", commit_valid, 0);
        dispatch_one(rd, rand_reg(), rand_reg());
        // First free register after the identity block
        check_value("rename_dest_tag", rename_dest_tag, rename_pkg::ARCH_REGS);
        check_value("rename_idx", rename_idx, 0);
        check_value("rename_old_tag", rename_old_tag, rd);
        report_test("reset_rename", errors_before);
    endtask

    task automatic dependency_chain();
        int errors_before;
        rename_pkg::arch_reg_t prev_rd;
        rename_pkg::arch_reg_t rd;
        errors_before = error_count;
        prev_rd = q_rd[q_rd.size() - 1];
        // Each instruction reads the previous destination
        for (int i = 0; i < 7; i++) begin
            rd = rand_reg();
            dispatch_one(rd, prev_rd, rand_reg());
            prev_rd = rd;
        end
        report_test("dependency_chain", errors_before);
    endtask

    task automatic in_order_retire();
        int errors_before;
        errors_before = error_count;
        // Younger entries done first so the head stays blocked
        complete_entry(q_idx[2]);
        check_value("commit_valid", commit_valid, 0);
        complete_entry(q_idx[1]);
        check_value("commit_valid", commit_valid, 0);
        complete_entry(q_idx[0]);
        repeat (3) retire_head();
        check_value("commit_valid", commit_valid, 0);
        report_test("in_order_retire", errors_before);
    endtask

    task automatic full_dispatch();
        int errors_before;
        errors_before = error_count;
        while (q_rd.size() < ROB_DEPTH) begin
            dispatch_one(rand_reg(), rand_reg(), rand_reg());
        end
        check_value("dispatch_ready", dispatch_ready, 0);
        // Strobe against a full ROB gives no response
        dispatch_valid = 1'b1;
        dispatch_rd    = rand_reg();
        next_cycle();
        dispatch_valid = 1'b0;
        check_value("rename_valid", rename_valid, 0);
        next_cycle();
        check_value("rename_valid", rename_valid, 0);
        // Retiring one returns a slot and its old tag
        complete_entry(q_idx[0]);
        retire_head();
        check_value("dispatch_ready", dispatch_ready, 1);
        dispatch_one(rand_reg(), rand_reg(), rand_reg());
        report_test("full_dispatch", errors_before);
    endtask

    task automatic flush_recovery();
        int errors_before;
        errors_before = error_count;
        // Flush in the same cycle as a done head wins over its commit
        complete_entry(q_idx[0]);
        flush = 1'b1;
        #1;
        check_value("commit_valid", commit_valid, 0);
        next_cycle();
        flush = 1'b0;
        model_flush();
        check_value("rename_valid", rename_valid, 0);
        check_value("commit_valid", commit_valid, 0);
        // Stale completions of the new head and its neighbor hit empty entries
        complete_entry(0);
        check_value("commit_valid", commit_valid, 0);
        complete_entry(1);
        check_value("commit_valid", commit_valid, 0);
        dispatch_one(rand_reg(), rand_reg(), rand_reg());
        check_value("rename_idx", rename_idx, 0);
        complete_entry(0);
        retire_head();
        // Nothing stale is left to retire
        check_value("commit_valid", commit_valid, 0);
        report_test("flush_recovery", errors_before);
    endtask

    initial begin
        seed           = 78;
        check_count    = 0;
        error_count    = 0;
        clock          = 1'b0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_rd    = '0;
        dispatch_rs1   = '0;
        dispatch_rs2   = '0;
        complete_valid = 1'b0;
        complete_idx   = '0;
        flush          = 1'b0;
        model_reset();
        repeat (2) @(posedge clock);
        #DRIVE_DELAY;
        rst = 1'b0;
        reset_rename();
        dependency_chain();
        in_order_retire();
        full_dispatch();
        flush_recovery();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: rename_core.f
rename_pkg.sv
map_table.sv
free_list.sv
reorder_buffer.sv
arch_map_table.sv
rename_core.sv
tb_rename_core.sv

// File: Bender.yml
package:
  name: rename_core

sources:
  - rename_pkg.sv
  - map_table.sv
  - free_list.sv
  - reorder_buffer.sv
  - arch_map_table.sv
  - rename_core.sv
  - target: test
    files:
      - tb_rename_core.sv
